//--- common/rv_m_pkg.sv
package rv_m_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] data_t;
	typedef logic [XLEN:0]   wide_t;	// operand plus one extension bit

	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;

	localparam funct7_t M_FUNCT7 = 7'b0000001;

	// funct3 encodings of the M extension
	typedef enum funct3_t {
		MUL    = 3'b000,
		MULH   = 3'b001,
		MULHSU = 3'b010,
		MULHU  = 3'b011,
		DIV    = 3'b100,
		DIVU   = 3'b101,
		REM    = 3'b110,
		REMU   = 3'b111
	} m_op_t;

	localparam int MUL_LATENCY = 3;	// multiplier pipeline depth

	// counter widths derived from the above
	localparam int MUL_CNT_W = $clog2(MUL_LATENCY + 1);
	localparam int DIV_CNT_W = $clog2(XLEN);

	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_FIX
	} div_state_t;

endpackage

//--- muldiv/m_decode.sv
`timescale 1ns/1ps

module m_decode (
	input  logic              clk,
	input  logic              reset,
	input  logic              op_valid,
	input  rv_m_pkg::funct7_t funct7,
	input  rv_m_pkg::funct3_t funct3,
	input  rv_m_pkg::data_t   rs1,
	input  rv_m_pkg::data_t   rs2,
	input  logic              div_done,
	output logic              busy,
	output logic              mul_start,
	output logic              div_start,
	output rv_m_pkg::m_op_t   op,
	output rv_m_pkg::wide_t   opa,
	output rv_m_pkg::wide_t   opb
);
	import rv_m_pkg::*;

	m_op_t                new_op;
	logic                 accept;
	logic                 is_div;
	logic                 sign_a;
	logic                 sign_b;
	logic                 div_pend;	// divide waiting for the multiplier to drain
	logic                 mul_idle;
	logic [MUL_CNT_W-1:0] mul_cnt;

	assign new_op   = m_op_t'(funct3);
	assign is_div   = funct3[2];
	assign accept   = op_valid && !reset && (funct7 == M_FUNCT7) && !busy;
	assign sign_a   = (new_op inside {MULH, MULHSU, DIV, REM}) && rs1[XLEN-1];
	assign sign_b   = (new_op inside {MULH, DIV, REM}) && rs2[XLEN-1];
	assign mul_idle = (mul_cnt == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy      <= 1'b0;
			mul_start <= 1'b0;
			div_start <= 1'b0;
			div_pend  <= 1'b0;
			mul_cnt   <= '0;
		end else begin
			mul_start <= accept && !is_div;
			div_start <= 1'b0;
			if (accept && !is_div) begin
				mul_cnt <= MUL_CNT_W'(MUL_LATENCY);	// reload on every issued multiply
			end else if (!mul_idle) begin
				mul_cnt <= mul_cnt - MUL_CNT_W'(1);
			end
			if (accept && is_div) begin
				busy <= 1'b1;
				if (mul_idle) begin
					div_start <= 1'b1;
				end else begin
					div_pend <= 1'b1;
				end
			end else if (div_pend && mul_idle) begin
				div_pend  <= 1'b0;
				div_start <= 1'b1;
			end else if (div_done) begin
				busy <= 1'b0;
			end
		end
	end

	// operands held stable until the next accepted strobe
	always_ff @(posedge clk) begin
		if (accept) begin
			op  <= new_op;
			opa <= {sign_a, rs1};
			opb <= {sign_b, rs2};
		end
	end

endmodule

//--- muldiv/multiplier.sv
`timescale 1ns/1ps

module multiplier (
	input  logic            clk,
	input  logic            reset,
	input  logic            mul_start,
	input  rv_m_pkg::m_op_t op,
	input  rv_m_pkg::wide_t opa,
	input  rv_m_pkg::wide_t opb,
	output logic            mul_done,
	output rv_m_pkg::data_t mul_res
);
	import rv_m_pkg::*;

	logic signed [2*XLEN+1:0] prod;	// full 33x33 signed product
	logic [2*XLEN-1:0]        prod_s1;
	logic [2*XLEN-1:0]        prod_s2;
	logic                     valid_s1;
	logic                     valid_s2;
	m_op_t                    op_s1;
	m_op_t                    op_s2;

	// extension bits make one signed multiply cover all four ops
	assign prod = $signed(opa) * $signed(opb);

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_s1 <= 1'b0;
			valid_s2 <= 1'b0;
			mul_done <= 1'b0;
		end else begin
			valid_s1 <= mul_start;
			valid_s2 <= valid_s1;
			mul_done <= valid_s2;
		end
	end

	always_ff @(posedge clk) begin
		prod_s1 <= prod[2*XLEN-1:0];	// top two bits are pure sign copies
		op_s1   <= op;
		prod_s2 <= prod_s1;
		op_s2   <= op_s1;
		if (op_s2 == MUL) begin
			mul_res <= prod_s2[XLEN-1:0];
		end else begin
			mul_res <= prod_s2[2*XLEN-1:XLEN];	// mulh, mulhsu, mulhu
		end
	end

endmodule

//--- muldiv/divider.sv
`timescale 1ns/1ps

module divider (
	input  logic            clk,
	input  logic            reset,
	input  logic            div_start,
	input  rv_m_pkg::m_op_t op,
	input  rv_m_pkg::wide_t opa,
	input  rv_m_pkg::wide_t opb,
	output logic            div_done,
	output rv_m_pkg::data_t div_res
);
	import rv_m_pkg::*;

	div_state_t           state;
	data_t                quo;	// dividend shifts out as quotient shifts in
	data_t                rem;
	data_t                dsr;
	logic [DIV_CNT_W-1:0] cnt;
	logic                 neg_q;
	logic                 neg_r;
	logic                 is_rem;
	logic                 sign_a;
	logic                 sign_b;
	logic                 div_zero;
	logic                 overflow;
	data_t                mag_a;
	data_t                mag_b;
	logic [XLEN:0]        shifted;
	logic [XLEN:0]        diff;
	data_t                quo_out;
	data_t                rem_out;

	// extension bit is set only for negative operands of signed ops
	assign sign_a   = opa[XLEN];
	assign sign_b   = opb[XLEN];
	assign mag_a    = sign_a ? -opa[XLEN-1:0] : opa[XLEN-1:0];
	assign mag_b    = sign_b ? -opb[XLEN-1:0] : opb[XLEN-1:0];
	assign div_zero = (opb[XLEN-1:0] == '0);
	assign overflow = (opa == {2'b11, {(XLEN-1){1'b0}}}) && (opb == '1);	// -2^31 / -1

	assign shifted = {rem, quo[XLEN-1]};
	assign diff    = shifted - {1'b0, dsr};
	assign quo_out = neg_q ? -quo : quo;
	assign rem_out = neg_r ? -rem : rem;

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= DIV_IDLE;
			div_done <= 1'b0;
		end else begin
			div_done <= 1'b0;
			case (state)
				DIV_IDLE: begin
					if (div_start) begin
						state <= (div_zero || overflow) ? DIV_FIX : DIV_RUN;
					end
				end
				DIV_RUN: begin
					if (cnt == DIV_CNT_W'(XLEN - 1)) begin
						state <= DIV_FIX;
					end
				end
				DIV_FIX: begin
					state    <= DIV_IDLE;
					div_done <= 1'b1;
				end
				default: state <= DIV_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			DIV_IDLE: begin
				if (div_start) begin
					is_rem <= op inside {REM, REMU};
					cnt    <= '0;
					dsr    <= mag_b;
					if (div_zero) begin
						quo   <= '1;
						rem   <= opa[XLEN-1:0];
						neg_q <= 1'b0;
						neg_r <= 1'b0;
					end else if (overflow) begin
						quo   <= {1'b1, {(XLEN-1){1'b0}}};
						rem   <= '0;
						neg_q <= 1'b0;
						neg_r <= 1'b0;
					end else begin
						quo   <= mag_a;
						rem   <= '0;
						neg_q <= sign_a ^ sign_b;
						neg_r <= sign_a;	// remainder follows the dividend
					end
				end
			end
			DIV_RUN: begin
				cnt <= cnt + DIV_CNT_W'(1);
				quo <= {quo[XLEN-2:0], !diff[XLEN]};
				rem <= diff[XLEN] ? shifted[XLEN-1:0] : diff[XLEN-1:0];	// restore on borrow
			end
			DIV_FIX: div_res <= is_rem ? rem_out : quo_out;
			default: begin
			end
		endcase
	end

endmodule

//--- muldiv/m_result.sv
`timescale 1ns/1ps

module m_result (
	input  logic            clk,
	input  logic            reset,
	input  logic            mul_done,
	input  logic            div_done,
	input  rv_m_pkg::data_t mul_res,
	input  rv_m_pkg::data_t div_res,
	output logic            result_valid,
	output rv_m_pkg::data_t result
);

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= mul_done || div_done;	// never both in one cycle
		end
	end

	// result holds its last value between valids
	always_ff @(posedge clk) begin
		if (mul_done) begin
			result <= mul_res;
		end else if (div_done) begin
			result <= div_res;
		end
	end

endmodule

//--- rtl/m_unit.sv
`timescale 1ns/1ps

module m_unit (
	input  logic              clk,
	input  logic              reset,
	input  logic              op_valid,
	input  rv_m_pkg::funct7_t funct7,
	input  rv_m_pkg::funct3_t funct3,
	input  rv_m_pkg::data_t   rs1,
	input  rv_m_pkg::data_t   rs2,
	output logic              busy,
	output logic              result_valid,
	output rv_m_pkg::data_t   result
);
	import rv_m_pkg::*;

	logic  mul_start;
	logic  div_start;
	logic  mul_done;
	logic  div_done;
	m_op_t op;
	wide_t opa;
	wide_t opb;
	data_t mul_res;
	data_t div_res;

	m_decode u_decode (
		.clk       (clk),
		.reset     (reset),
		.op_valid  (op_valid),
		.funct7    (funct7),
		.funct3    (funct3),
		.rs1       (rs1),
		.rs2       (rs2),
		.div_done  (div_done),
		.busy      (busy),
		.mul_start (mul_start),
		.div_start (div_start),
		.op        (op),
		.opa       (opa),
		.opb       (opb)
	);

	multiplier u_mul (
		.clk       (clk),
		.reset     (reset),
		.mul_start (mul_start),
		.op        (op),
		.opa       (opa),
		.opb       (opb),
		.mul_done  (mul_done),
		.mul_res   (mul_res)
	);

	divider u_div (
		.clk       (clk),
		.reset     (reset),
		.div_start (div_start),
		.op        (op),
		.opa       (opa),
		.opb       (opb),
		.div_done  (div_done),
		.div_res   (div_res)
	);

	m_result u_result (
		.clk          (clk),
		.reset        (reset),
		.mul_done     (mul_done),
		.div_done     (div_done),
		.mul_res      (mul_res),
		.div_res      (div_res),
		.result_valid (result_valid),
		.result       (result)
	);

endmodule

//--- sim/m_model.svh
`ifndef M_MODEL_SVH
`define M_MODEL_SVH

// multiply reference in plain 64-bit arithmetic
function automatic data_t mul_model(input funct3_t f3, input data_t a, input data_t b);
	logic [63:0] p;
	case (f3)
		MULH:    p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
		MULHSU:  p = $signed({{32{a[31]}}, a}) * $signed({32'b0, b});
		default: p = {32'b0, a} * {32'b0, b};	// mul and mulhu
	endcase
	return (f3 == MUL) ? p[31:0] : p[63:32];
endfunction

// divide reference with the ISA results for zero divisor and overflow
function automatic data_t div_model(input funct3_t f3, input data_t a, input data_t b);
	logic signed [31:0] sa;
	logic signed [31:0] sb;
	logic               signed_op;
	data_t              q;
	data_t              r;
	sa        = a;
	sb        = b;
	signed_op = (f3 == DIV) || (f3 == REM);
	if (b == 32'h0) begin
		q = 32'hffff_ffff;
		r = a;
	end else if (signed_op && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
		q = a;
		r = 32'h0;
	end else if (signed_op) begin
		q = sa / sb;	// truncates toward zero
		r = sa % sb;
	end else begin
		q = a / b;
		r = a % b;
	end
	return (f3 == REM || f3 == REMU) ? r : q;
endfunction

function automatic data_t model_result(input funct3_t f3, input data_t a, input data_t b);
	return f3[2] ? div_model(f3, a, b) : mul_model(f3, a, b);
endfunction

`endif

//--- sim/m_unit_tb.sv
`timescale 1ns/1ps

module m_unit_tb;
	import rv_m_pkg::*;

	localparam int num_ops = 160;
	localparam int cycles_per_op = 40;

	logic    clk;
	logic    reset;
	logic    op_valid;
	funct7_t funct7;
	funct3_t funct3;
	data_t   rs1;
	data_t   rs2;
	logic    busy;
	logic    result_valid;
	data_t   result;

	data_t   rng_state;
	data_t   exp_val [$];
	int      exp_cyc [$];	// sampling cycle of the accepted strobe
	bit      exp_mul [$];
	int      cycle;
	logic    reset_d;
	logic    div_out;	// a divide is accepted and its result not yet seen

	`include "m_model.svh"

	m_unit DUT (
		.clk          (clk),
		.reset        (reset),
		.op_valid     (op_valid),
		.funct7       (funct7),
		.funct3       (funct3),
		.rs1          (rs1),
		.rs2          (rs2),
		.busy         (busy),
		.result_valid (result_valid),
		.result       (result)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic data_t xorshift(input data_t x);
		data_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic data_t next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic send_op(input funct7_t f7, input funct3_t f3, input data_t a, input data_t b);
		@(posedge clk);
		op_valid <= 1'b1;
		funct7   <= f7;
		funct3   <= f3;
		rs1      <= a;
		rs2      <= b;
	endtask

	// release the strobe and wait until every accepted op has returned
	task automatic drain();
		int waited;
		waited = 0;
		@(posedge clk);
		op_valid <= 1'b0;
		@(negedge clk);
		while (exp_val.size() != 0) begin
			@(negedge clk);
			waited++;
			if (waited > 100) begin
				$display("no result within 100 cycles, %0d ops outstanding", exp_val.size());
				abort_run();
			end
		end
		repeat (4) @(posedge clk);
	endtask

	task automatic check_result();
		int lat;
		assert (exp_val.size() > 0) else begin
			$display("result_valid was raised with no operation outstanding");
			abort_run();
		end
		lat = cycle - exp_cyc[0];
		assert (result == exp_val[0]) else begin
			$display("ERR %0t: result %h, expected %h", $time, result, exp_val[0]);
			abort_run();
		end
		if (exp_mul[0]) begin
			assert (lat == 5) else begin
				$display("ERR %0t: multiply latency %0d, expected 5", $time, lat);
				abort_run();
			end
		end else begin
			assert (lat <= 40) else begin
				$display("ERR %0t: divide latency %0d, expected at most 40", $time, lat);
				abort_run();
			end
			div_out = 1'b0;
		end
		void'(exp_val.pop_front());
		void'(exp_cyc.pop_front());
		void'(exp_mul.pop_front());
	endtask

	// scoreboard sampled on the same edge as the DUT
	always @(posedge clk) begin
		cycle++;
		reset_d <= reset;
		if (reset_d) begin
			assert (!busy && !result_valid) else begin
				$display("busy or result_valid was high during or right after reset");
				abort_run();
			end
		end
		if (!reset) begin
			if (result_valid) begin
				check_result();
			end
			assert (busy == div_out) else begin
				$display("ERR %0t: busy %b, expected %b", $time, busy, div_out);
				abort_run();
			end
			if (op_valid && funct7 == M_FUNCT7 && !div_out) begin
				exp_val.push_back(model_result(funct3, rs1, rs2));
				exp_cyc.push_back(cycle);
				exp_mul.push_back(!funct3[2]);
				div_out = funct3[2];
			end
		end
	end

	initial begin
		repeat (num_ops * cycles_per_op + 500) @(posedge clk);
		$display("watchdog expired before the tests finished");
		abort_run();
	end

	initial begin
		data_t corners [4];
		data_t a;
		data_t b;
		data_t r;
		op_valid  = 1'b0;
		funct7    = '0;
		funct3    = '0;
		rs1       = '0;
		rs2       = '0;
		reset     = 1'b1;
		reset_d   = 1'b0;
		div_out   = 1'b0;
		cycle     = 0;
		rng_state = 32'd76;
		corners   = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		repeat (2) @(posedge clk);

		// corner operands issued back to back
		for (int op = 0; op < 4; op++) begin
			for (int i = 0; i < 4; i++) begin
				for (int j = 0; j < 4; j++) begin
					send_op(M_FUNCT7, funct3_t'(op), corners[i], corners[j]);
				end
			end
		end
		drain();
		repeat (40) begin
			r = next_rand();
			send_op(M_FUNCT7, {1'b0, r[1:0]}, next_rand(), next_rand());
		end
		drain();

		for (int k = 0; k < 24; k++) begin
			a = next_rand();
			r = next_rand();
			b = next_rand() >> r[4:0];	// spread of divisor sizes
			if (r[5]) b = -b;
			if (b == 32'h0) b = 32'h1;
			send_op(M_FUNCT7, funct3_t'(4 + (k % 4)), a, b);
			drain();
		end

		for (int op = 4; op < 8; op++) begin
			for (int i = 0; i < 4; i++) begin
				send_op(M_FUNCT7, funct3_t'(op), corners[i], 32'h0);
				drain();
			end
			send_op(M_FUNCT7, funct3_t'(op), 32'h8000_0000, 32'hffff_ffff);
			drain();
		end

		// strobes that must not produce a result
		send_op(7'b0000000, MUL, next_rand(), next_rand());
		send_op(7'b0100000, DIV, next_rand(), next_rand());
		send_op(7'b0000000, MULHU, next_rand(), next_rand());
		send_op(7'b1000001, REMU, next_rand(), next_rand());
		drain();
		send_op(M_FUNCT7, DIV, next_rand(), next_rand() | 32'h1);
		send_op(M_FUNCT7, MUL, next_rand(), next_rand());
		send_op(M_FUNCT7, MULH, next_rand(), next_rand());
		send_op(M_FUNCT7, REMU, next_rand(), next_rand());
		drain();
		send_op(M_FUNCT7, MULH, next_rand(), next_rand());
		send_op(M_FUNCT7, DIV, next_rand(), next_rand() | 32'h1);	// waits for the multiply
		send_op(M_FUNCT7, MUL, next_rand(), next_rand());
		drain();

		repeat (20) @(posedge clk);
		if (exp_val.size() != 0) begin
			$display("%0d operations never returned a result", exp_val.size());
			abort_run();
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

//--- compile.f
+incdir+sim
common/rv_m_pkg.sv
muldiv/m_decode.sv
muldiv/multiplier.sv
muldiv/divider.sv
muldiv/m_result.sv
rtl/m_unit.sv
sim/m_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f compile.f --top-module m_unit_tb -o m_unit_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/m_unit_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "RESULT: PASS"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1
